// File: src/decodePkg.sv
package decodePkg;

   // Width of every data word, address and PC in the machine
   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;  // Eight architectural registers R0 to R7

   // JAL and JALR always deposit their return address in R7
   localparam logic [regAddrWidth-1:0] linkReg = 3'd7;

   // Major opcode taken from instr[15:11]
   // Encodings that are not listed here fall into the "other" group
   // and carry no control flow for the decode stage
   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100, // PC-relative jump with an 11-bit displacement
      opJr   = 5'b00101, // Register jump, Rs plus the 8-bit immediate
      opJal  = 5'b00110,
      opJalr = 5'b00111,
      opBeqz = 5'b01100, // The four branches share the 011xx prefix
      opBnez = 5'b01101,
      opBltz = 5'b01110,
      opBgez = 5'b01111,
      opLbi  = 5'b11000  // Load byte immediate goes through writeback
   } opcodeT;

   // Branch compare against zero, selected by instr[12:11]
   typedef enum logic [1:0] {
      condEqz = 2'b00, // Taken when Rs equals zero
      condNez = 2'b01,
      condLtz = 2'b10, // Sign bit set
      condGez = 2'b11  // Sign bit clear
   } branchCondT;

endpackage

// File: src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import decodePkg::*; (
   input  logic [dataWidth-1:0]    instr,     // Instruction sitting in decode
   output logic [regAddrWidth-1:0] rsAddr,    // First source register
   output logic [regAddrWidth-1:0] rtAddr,    // Second source register
   output logic                    isBranch,  // One of the zero-compare branches
   output logic                    isJump,    // J or JAL
   output logic                    isJumpReg, // JR or JALR
   output logic                    isLink,    // JAL or JALR
   output branchCondT              cond,      // Compare used by a branch
   output logic [dataWidth-1:0]    imm8Ext,   // Sign-extended instr[7:0]
   output logic [dataWidth-1:0]    imm11Ext   // Sign-extended instr[10:0]
);

   opcodeT opcode; // Major opcode of the current instruction

   // Unknown encodings still cast cleanly and simply match no case item
   assign opcode = opcodeT'(instr[15:11]);

   // Register fields sit at fixed positions in every format
   assign rsAddr = instr[10:8];
   assign rtAddr = instr[7:5];

   // The two low opcode bits double as the branch compare select
   assign cond = branchCondT'(instr[12:11]);

   // Group the opcodes into the control classes used downstream
   always_comb begin
      isBranch  = 1'b0;
      isJump    = 1'b0;
      isJumpReg = 1'b0;
      isLink    = 1'b0;
      case (opcode)
         opJ: begin
            isJump = 1'b1;
         end
         opJal: begin
            isJump = 1'b1;
            isLink = 1'b1; // Return address goes to R7
         end
         opJr: begin
            isJumpReg = 1'b1;
         end
         opJalr: begin
            isJumpReg = 1'b1;
            isLink    = 1'b1;
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            isBranch = 1'b1; // Compare itself is picked by cond
         end
         opHalt, opNop, opLbi: begin
            // Halt comes in on its own input and LBI is a plain writeback
         end
         default: begin
            // ALU and memory formats leave the PC alone
         end
      endcase
   end

   // I-format immediate used by branches, JR and JALR
   assign imm8Ext = {{(dataWidth-8){instr[7]}}, instr[7:0]};

   // J-format displacement for J and JAL
   assign imm11Ext = {{(dataWidth-11){instr[10]}}, instr[10:0]};

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile import decodePkg::*; #(
   parameter int numRegs = 8 // Number of words held
) (
   input  logic                    clk,
   input  logic                    arstN,
   input  logic [regAddrWidth-1:0] rdAddr1,     // Rs read port
   input  logic [regAddrWidth-1:0] rdAddr2,     // Rt read port
   output logic [dataWidth-1:0]    rdData1,
   output logic [dataWidth-1:0]    rdData2,
   input  logic                    linkWrEn,    // Return address write from decode
   input  logic [regAddrWidth-1:0] linkWrAddr,
   input  logic [dataWidth-1:0]    linkWrData,
   input  logic                    wbWrEn,      // Result write from writeback
   input  logic [regAddrWidth-1:0] wbWrAddr,
   input  logic [dataWidth-1:0]    wbWrData
);

   logic [dataWidth-1:0] regs [numRegs]; // Architectural register state

   // Value seen by a read port, with writes of this cycle bypassed in
   function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
      logic [dataWidth-1:0] value;
      value = regs[addr];
      if (wbWrEn && (wbWrAddr == addr)) begin
         value = wbWrData;
      end
      // Link data is checked last so it beats a writeback to the same register
      if (linkWrEn && (linkWrAddr == addr)) begin
         value = linkWrData;
      end
      return value;
   endfunction

   always_comb begin
      rdData1 = readPort(rdAddr1);
      rdData2 = readPort(rdAddr2);
   end

   // Both ports commit on the same edge, later assignment wins on a clash
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wbWrEn) begin
            regs[wbWrAddr] <= wbWrData;
         end
         if (linkWrEn) begin
            regs[linkWrAddr] <= linkWrData; // Link port has priority
         end
      end
   end

endmodule

// File: src/branchResolver.sv
`timescale 1ns/1ps

module branchResolver import decodePkg::*; (
   input  logic [dataWidth-1:0] pc,        // Address of the instruction in decode
   input  logic [dataWidth-1:0] rsData,    // Rs as read from the register file
   input  logic [dataWidth-1:0] exRsData,  // Rs forwarded from execute
   input  logic [dataWidth-1:0] memRsData, // Rs forwarded from memory
   input  logic                 fwdEx,
   input  logic                 fwdMem,
   input  logic                 halt,      // Stops any redirect
   input  logic                 isBranch,
   input  logic                 isJump,
   input  logic                 isJumpReg,
   input  branchCondT           cond,
   input  logic [dataWidth-1:0] imm8Ext,
   input  logic [dataWidth-1:0] imm11Ext,
   output logic                 pcSel,     // High when fetch must take nextPc
   output logic [dataWidth-1:0] nextPc
);

   localparam logic [dataWidth-1:0] pcStep = 2; // Instructions are two bytes

   logic [dataWidth-1:0] rsFwd;        // Freshest value of Rs
   logic                 rsZero;
   logic                 rsNeg;
   logic                 condMet;      // Branch compare holds
   logic [dataWidth-1:0] pcInc;        // Fall-through address
   logic [dataWidth-1:0] branchTarget;
   logic [dataWidth-1:0] jumpTarget;
   logic [dataWidth-1:0] regTarget;

   // Execute holds the younger producer so it is preferred over memory
   always_comb begin
      if (fwdEx) begin
         rsFwd = exRsData;
      end else if (fwdMem) begin
         rsFwd = memRsData;
      end else begin
         rsFwd = rsData;
      end
   end

   assign rsZero = (rsFwd == '0);
   assign rsNeg  = rsFwd[dataWidth-1]; // Two's complement sign

   always_comb begin
      unique case (cond)
         condEqz: condMet = rsZero;
         condNez: condMet = !rsZero;
         condLtz: condMet = rsNeg;
         condGez: condMet = !rsNeg;
      endcase
   end

   // Targets are all formed in parallel and picked below
   assign pcInc        = pc + pcStep;
   assign branchTarget = pcInc + imm8Ext;
   assign jumpTarget   = pcInc + imm11Ext;
   assign regTarget    = rsFwd + imm8Ext; // JR and JALR are not PC-relative

   // Jumps are unconditional, branches need their compare
   assign pcSel = !halt && (isJump || isJumpReg || (isBranch && condMet));

   always_comb begin
      if (!pcSel) begin
         nextPc = pcInc;
      end else if (isJumpReg) begin
         nextPc = regTarget;
      end else if (isJump) begin
         nextPc = jumpTarget;
      end else begin
         nextPc = branchTarget; // Only a taken branch is left
      end
   end

endmodule

// File: src/linkTracker.sv
`timescale 1ns/1ps

module linkTracker import decodePkg::*; (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic                 isLink,     // JAL or JALR in decode
   input  logic                 halt,
   input  logic                 wbEn,       // Writeback wants to write a register
   input  logic [dataWidth-1:0] pc,         // Address of the instruction in decode
   output logic                 linkWrEn,   // Write R7 at the end of this cycle
   output logic [dataWidth-1:0] linkWrData, // Return address
   output logic                 wbWrEn      // Writeback enable after filtering
);

   localparam logic [dataWidth-1:0] pcStep = 2;

   // One flag per later pipeline stage, set while a link instruction is there
   logic exLink;
   logic memLink;
   logic wbLink;

   // The return address is written straight from decode
   // so a following JR R7 sees it without any forwarding
   assign linkWrEn   = isLink && !halt;
   assign linkWrData = pc + pcStep;

   // Shadow of the link instruction as it moves down the pipe
   // There are no stalls so one shift per clock keeps it aligned
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exLink  <= 1'b0;
         memLink <= 1'b0;
         wbLink  <= 1'b0;
      end else begin
         exLink  <= isLink;
         memLink <= exLink;
         wbLink  <= memLink; // Reaches writeback three cycles after decode
      end
   end

   // R7 already holds the link value so the late writeback must be dropped
   assign wbWrEn = wbEn && !wbLink;

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import decodePkg::*; #(
   parameter int numRegs = 8 // Register file depth handed to regFile
) (
   input  logic                    clk,
   input  logic                    arstN,
   input  logic [dataWidth-1:0]    instr,     // Instruction in decode
   input  logic [dataWidth-1:0]    pc,        // Its address
   input  logic                    wbEn,      // Writeback request from the last stage
   input  logic [regAddrWidth-1:0] wbAddr,
   input  logic [dataWidth-1:0]    wbData,
   input  logic [dataWidth-1:0]    exRsData,  // Forwarding sources for Rs
   input  logic [dataWidth-1:0]    memRsData,
   input  logic                    fwdEx,
   input  logic                    fwdMem,
   input  logic                    halt,
   output logic [dataWidth-1:0]    rsData,
   output logic [dataWidth-1:0]    rtData,
   output logic [dataWidth-1:0]    immOut,    // Sign-extended imm8 for execute
   output logic                    pcSel,
   output logic [dataWidth-1:0]    nextPc
);

   logic [regAddrWidth-1:0] rsAddr;
   logic [regAddrWidth-1:0] rtAddr;
   logic                    isBranch;
   logic                    isJump;
   logic                    isJumpReg;
   logic                    isLink;
   branchCondT              cond;
   logic [dataWidth-1:0]    imm8Ext;
   logic [dataWidth-1:0]    imm11Ext;
   logic                    linkWrEn;   // Return address write enable
   logic [dataWidth-1:0]    linkWrData;
   logic                    wbWrEn;     // Writeback enable with link cycles removed

   instrDecoder decoder (
      .instr, .rsAddr, .rtAddr, .isBranch, .isJump, .isJumpReg, .isLink,
      .cond, .imm8Ext, .imm11Ext
   );

   // Link writes always target R7
   regFile #(.numRegs(numRegs)) regs (
      .clk, .arstN,
      .rdAddr1(rsAddr), .rdAddr2(rtAddr), .rdData1(rsData), .rdData2(rtData),
      .linkWrEn, .linkWrAddr(linkReg), .linkWrData,
      .wbWrEn, .wbWrAddr(wbAddr), .wbWrData(wbData)
   );

   branchResolver resolver (
      .pc, .rsData, .exRsData, .memRsData, .fwdEx, .fwdMem, .halt,
      .isBranch, .isJump, .isJumpReg, .cond, .imm8Ext, .imm11Ext,
      .pcSel, .nextPc
   );

   linkTracker tracker (
      .clk, .arstN, .isLink, .halt, .wbEn, .pc, .linkWrEn, .linkWrData, .wbWrEn
   );

   assign immOut = imm8Ext; // Execute only ever needs the I-format immediate

endmodule

// File: testbench/decodeTb.sv
`timescale 1ns/1ps

module decodeTb import decodePkg::*; ();

   localparam int resetCycles = 16; // Clock cycles with arstN held low
   localparam int fieldCount  = 15; // Columns on one stimulus line
   localparam int spareCycles = 20; // Slack on top of reset and vectors

   // One line of the stimulus file with the inputs first and the expected outputs after them
   typedef struct packed {
      logic [dataWidth-1:0]    instr;
      logic [dataWidth-1:0]    pc;
      logic                    wbEn;
      logic [regAddrWidth-1:0] wbAddr;
      logic [dataWidth-1:0]    wbData;
      logic [dataWidth-1:0]    exRsData;
      logic [dataWidth-1:0]    memRsData;
      logic                    fwdEx;
      logic                    fwdMem;
      logic                    halt;
      logic [dataWidth-1:0]    expRs;
      logic [dataWidth-1:0]    expRt;
      logic [dataWidth-1:0]    expImm;
      logic                    expPcSel;
      logic [dataWidth-1:0]    expNextPc;
   } vectorT;

   logic                    clk;
   logic                    arstN;
   logic [dataWidth-1:0]    instr;
   logic [dataWidth-1:0]    pc;
   logic                    wbEn;
   logic [regAddrWidth-1:0] wbAddr;
   logic [dataWidth-1:0]    wbData;
   logic [dataWidth-1:0]    exRsData;
   logic [dataWidth-1:0]    memRsData;
   logic                    fwdEx;
   logic                    fwdMem;
   logic                    halt;
   logic [dataWidth-1:0]    rsData;
   logic [dataWidth-1:0]    rtData;
   logic [dataWidth-1:0]    immOut;
   logic                    pcSel;
   logic [dataWidth-1:0]    nextPc;

   vectorT vectors [$];   // Whole stimulus file, loaded before reset ends
   int cycleCount = 0;
   int cycleLimit = 0;    // Stays zero until the vector count is known
   int vecIndex   = 0;    // Index of the vector under test for error lines

   decodeStage #(.numRegs(8)) UUT (
      .clk, .arstN, .instr, .pc, .wbEn, .wbAddr, .wbData, .exRsData, .memRsData,
      .fwdEx, .fwdMem, .halt, .rsData, .rtData, .immOut, .pcSel, .nextPc
   );

   always #5 clk = ~clk; // 10 ns period

   // Watchdog on rising edges
   always @(posedge clk) begin
      cycleCount++;
      if ((cycleLimit > 0) && (cycleCount > cycleLimit)) begin
         $display("Timeout after %0d cycles, the vector loop did not finish", cycleCount);
         $display("Something failed");
         $fatal(1, "Run stopped by the cycle counter");
      end
   end

   // Reads every data line of the stimulus file and skips lines that start with //
   task automatic loadVectors();
      int fd;
      int count;
      string line;
      logic [dataWidth-1:0] f [fieldCount];
      vectorT vec;
      fd = $fopen("testbench/decodeStim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file testbench/decodeStim.txt");
         $display("Something failed");
         $fatal(1, "Missing stimulus file");
      end
      while (!$feof(fd)) begin
         line = "";
         count = $fgets(line, fd);
         if ((count > 0) && !((line.len() >= 2) && (line.substr(0, 1) == "//"))) begin
            count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                            f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (count == fieldCount) begin
               vec.instr     = f[0];
               vec.pc        = f[1];
               vec.wbEn      = f[2][0];
               vec.wbAddr    = f[3][regAddrWidth-1:0];
               vec.wbData    = f[4];
               vec.exRsData  = f[5];
               vec.memRsData = f[6];
               vec.fwdEx     = f[7][0];
               vec.fwdMem    = f[8][0];
               vec.halt      = f[9][0];
               vec.expRs     = f[10];
               vec.expRt     = f[11];
               vec.expImm    = f[12];
               vec.expPcSel  = f[13][0];
               vec.expNextPc = f[14];
               vectors.push_back(vec);
            end else if (count > 0) begin
               $display("Stimulus line %0d has %0d columns instead of %0d",
                        vectors.size(), count, fieldCount);
               $display("Something failed");
               $fatal(1, "Malformed stimulus file");
            end
         end
      end
      $fclose(fd);
   endtask

   // Inputs change on the falling edge half a period away from the register update
   task automatic applyVector(input vectorT vec);
      instr     = vec.instr;
      pc        = vec.pc;
      wbEn      = vec.wbEn;
      wbAddr    = vec.wbAddr;
      wbData    = vec.wbData;
      exRsData  = vec.exRsData;
      memRsData = vec.memRsData;
      fwdEx     = vec.fwdEx;
      fwdMem    = vec.fwdMem;
      halt      = vec.halt;
   endtask

   task automatic checkValue(input string name, input logic [dataWidth-1:0] actual,
                             input logic [dataWidth-1:0] expected);
      if (actual !== expected) begin
         $display("Fail at %0t: %s is %h, expected %h in vector %0d",
                  $time, name, actual, expected, vecIndex);
         $display("Something failed");
         $fatal(1, "Output mismatch");
      end
   endtask

   task automatic checkOutputs(input vectorT vec);
      checkValue("rsData", rsData, vec.expRs);
      checkValue("rtData", rtData, vec.expRt);
      checkValue("immOut", immOut, vec.expImm);
      checkValue("pcSel", {15'd0, pcSel}, {15'd0, vec.expPcSel}); // Widened to fit the checker
      checkValue("nextPc", nextPc, vec.expNextPc);
   endtask

   initial begin
      clk       = 1'b0;
      arstN     = 1'b0;
      instr     = 16'h0800; // NOP with R0 in both source fields
      pc        = 16'h0000;
      wbEn      = 1'b0;
      wbAddr    = 3'd0;
      wbData    = 16'h0000;
      exRsData  = 16'h0000;
      memRsData = 16'h0000;
      fwdEx     = 1'b0;
      fwdMem    = 1'b0;
      halt      = 1'b0;
      loadVectors();
      cycleLimit = resetCycles + vectors.size() + spareCycles;
      repeat (resetCycles) @(negedge clk);
      arstN = 1'b1;
      foreach (vectors[i]) begin
         @(negedge clk);
         vecIndex = i;
         applyVector(vectors[i]);
         #4; // One nanosecond before the rising edge
         checkOutputs(vectors[i]);
      end
      $display("Everything OK");
      $finish;
   end

endmodule

// File: testbench/decodeStim.txt
// instr pc wbEn wbAddr wbData exRs memRs fwdEx fwdMem halt | rsData rtData immOut pcSel nextPc
// All columns hex, the expected outputs are the last five
// Every register reads zero after reset
0940 0100 0 0 0000 0000 0000 0 0 0 0000 0000 0040 0 0102
0B80 0102 0 0 0000 0000 0000 0 0 0 0000 0000 FF80 0 0104
0DC0 0104 0 0 0000 0000 0000 0 0 0 0000 0000 FFC0 0 0106
0F00 0106 0 0 0000 0000 0000 0 0 0 0000 0000 0000 0 0108
// Writeback fills R1, R3, R4 and R5, same-cycle reads see the new data
0900 0108 1 1 1234 0000 0000 0 0 0 1234 0000 0000 0 010A
0960 010A 1 3 0005 0000 0000 0 0 0 1234 0005 0060 0 010C
0C60 010C 1 4 8003 0000 0000 0 0 0 8003 0005 0060 0 010E
0D20 010E 1 5 00F0 0000 0000 0 0 0 00F0 1234 0020 0 0110
// BEQZ, BNEZ, BLTZ and BGEZ on R2 zero, R3 positive and R4 negative
6210 0200 0 0 0000 0000 0000 0 0 0 0000 0000 0010 1 0212
6310 0202 0 0 0000 0000 0000 0 0 0 0005 0000 0010 0 0204
64F0 0204 0 0 0000 0000 0000 0 0 0 8003 0000 FFF0 0 0206
6A10 0206 0 0 0000 0000 0000 0 0 0 0000 0000 0010 0 0208
6BF0 0208 0 0 0000 0000 0000 0 0 0 0005 0000 FFF0 1 01FA
6C10 020A 0 0 0000 0000 0000 0 0 0 8003 0000 0010 1 021C
7210 020C 0 0 0000 0000 0000 0 0 0 0000 0000 0010 0 020E
7310 020E 0 0 0000 0000 0000 0 0 0 0005 0000 0010 0 0210
74F0 0210 0 0 0000 0000 0000 0 0 0 8003 0000 FFF0 1 0202
7A10 0212 0 0 0000 0000 0000 0 0 0 0000 0000 0010 1 0224
7BF0 0214 0 0 0000 0000 0000 0 0 0 0005 0000 FFF0 1 0206
7C10 0216 0 0 0000 0000 0000 0 0 0 8003 0000 0010 0 0218
// Forwarded Rs from execute and memory, execute wins when both are set
6210 0218 0 0 0000 0007 0000 1 0 0 0000 0000 0010 0 021A
6310 021A 0 0 0000 0000 0000 0 1 0 0005 0000 0010 1 022C
7310 021C 0 0 0000 8000 0001 1 1 0 0005 0000 0010 1 022E
7C10 021E 0 0 0000 0000 FFFF 1 1 0 8003 0000 0010 1 0230
6AF0 0220 0 0 0000 0000 FFFE 0 1 0 0000 0000 FFF0 1 0212
// J and JR with negative and positive displacements
27F0 0300 0 0 0000 0000 0000 0 0 0 0000 0000 FFF0 1 02F2
2100 0302 0 0 0000 0000 0000 0 0 0 1234 0000 0000 1 0404
2DF8 0304 0 0 0000 0000 0000 0 0 0 00F0 0000 FFF8 1 00E8
2D04 0306 0 0 0000 4000 0000 1 0 0 00F0 0000 0004 1 4004
2980 0308 0 0 0000 0000 1000 0 1 0 1234 8003 FF80 1 0F80
// JAL links R7, the writeback three cycles later is dropped
37E0 0400 0 0 0000 0000 0000 0 0 0 0402 0402 FFE0 1 03E2
0FC0 0402 1 6 0066 0000 0000 0 0 0 0402 0066 FFC0 0 0404
0EE0 0404 0 0 0000 0000 0000 0 0 0 0066 0402 FFE0 0 0406
0F00 0406 1 7 DEAD 0000 0000 0 0 0 0402 0000 0000 0 0408
0FC0 0408 1 6 0077 0000 0000 0 0 0 0402 0077 FFC0 0 040A
// Halt blocks redirects and the JAL link write
6210 0500 0 0 0000 0000 0000 0 0 1 0000 0000 0010 0 0502
27F0 0502 0 0 0000 0000 0000 0 0 1 0402 0402 FFF0 0 0504
37E0 0504 0 0 0000 0000 0000 0 0 1 0402 0402 FFE0 0 0506
0F00 0506 0 0 0000 0000 0000 0 0 0 0402 0000 0000 0 0508
// JALR through R5, then its late writeback to R7 is dropped
3D00 0600 0 0 0000 0000 0000 0 0 0 00F0 0000 0000 1 00F0
0F00 0602 0 0 0000 0000 0000 0 0 0 0602 0000 0000 0 0604
09E0 0604 1 1 BEEF 0000 0000 0 0 0 BEEF 0602 FFE0 0 0606
0F20 0606 1 7 1111 0000 0000 0 0 0 0602 BEEF 0020 0 0608
0F20 0608 0 0 0000 0000 0000 0 0 0 0602 BEEF 0020 0 060A

// File: build.f
src/decodePkg.sv
src/instrDecoder.sv
src/regFile.sv
src/branchResolver.sv
src/linkTracker.sv
src/decodeStage.sv
testbench/decodeTb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = decodeTb
FILELIST  = build.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

SOURCES = $(shell cat $(FILELIST)) testbench/decodeStim.txt

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || { echo "Simulation ended early, see $(LOG)"; exit 1; }

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
